/* logic/pyramidPkg.sv */
package pyramidPkg;

    //////////////////////////////////////////////////
    // pixel and level widths
    //////////////////////////////////////////////////
    localparam int PIX_W = 8;
    localparam int LVL_W = 3;       // enough for SIDE 64 down to WIN 4

    //////////////////////////////////////////////////
    // wishbone register map
    //////////////////////////////////////////////////
    localparam logic [15:0] CTRL_ADDR = 16'hFFFF;    // control/status word

    localparam int CTRL_START = 0;  // write bit, starts a run
    localparam int STAT_BUSY  = 0;  // read bits
    localparam int STAT_DONE  = 1;

    //////////////////////////////////////////////////
    // sequencer states
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE,
        SCAN,           // one read per cycle inside a window
        DRAIN,          // last read data lands
        HANDOFF,        // window waits for the classifier
        NEXT_LEVEL
    } seqState_t;

    // side of the decimated image at a given level
    function automatic int levelSide(input int side, input int lvl);
        int result;
        result = side >> lvl;
        return result;
    endfunction

endpackage

/* logic/wbFrameLoader.sv */
`timescale 1ns/1ps

module wbFrameLoader import pyramidPkg::*; #(
    parameter  int SIDE = 32,
    parameter  int WIN  = 8,
    localparam int AW   = 2 * $clog2(SIDE)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wbCyc,
    input  logic             wbStb,
    input  logic             wbWe,
    input  logic [15:0]      wbAdr,
    input  logic [PIX_W-1:0] wbDatW,
    input  logic             busy,
    input  logic             done,
    output logic [PIX_W-1:0] wbDatR,
    output logic             wbAck,
    output logic             loadWe,
    output logic [AW-1:0]    loadAddr,
    output logic [PIX_W-1:0] loadData,
    output logic             start
);

    if (SIDE < 2 * WIN) begin : gParamCheck
        $error("frame side must be at least two windows wide");
    end

    logic req;
    logic pixHit, ctrlHit;
    logic idle;

    assign req     = wbCyc & wbStb & ~wbAck;    // new request, not yet acked
    assign pixHit  = (wbAdr[15:AW] == '0);
    assign ctrlHit = (wbAdr == CTRL_ADDR);
    assign idle    = ~busy & ~start;            // start pulse counts as busy already

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wbAck  <= 1'b0;
            loadWe <= 1'b0;
            start  <= 1'b0;
        end else begin
            wbAck  <= req;
            loadWe <= req & wbWe & pixHit & idle;
            start  <= req & wbWe & ctrlHit & wbDatW[CTRL_START] & idle;
        end
    end

    // payload, captured with the request
    always_ff @(posedge clk) begin
        loadAddr <= wbAdr[AW-1:0];      // row*SIDE + col
        loadData <= wbDatW;
        wbDatR            <= '0;
        wbDatR[STAT_BUSY] <= busy;
        wbDatR[STAT_DONE] <= done;
    end

    // no frame write may slip into a running scan
    assert property (@(posedge clk) disable iff (!rst_n) busy |-> !loadWe)
        else $error("pixel write reached the frame RAM while busy");

endmodule

/* logic/frameRam.sv */
`timescale 1ns/1ps

module frameRam import pyramidPkg::*; #(
    parameter  int SIDE = 32,
    parameter  int WIN  = 8,
    localparam int AW   = 2 * $clog2(SIDE)
) (
    input  logic             clk,
    input  logic             loadWe,
    input  logic [AW-1:0]    loadAddr,
    input  logic [PIX_W-1:0] loadData,
    input  logic             decWe,
    input  logic             decBank,
    input  logic [AW-1:0]    decAddr,
    input  logic             rdEn,
    input  logic             rdBank,
    input  logic [AW-1:0]    rdAddr,
    output logic [PIX_W-1:0] rdData
);

    if (SIDE != 2 ** $clog2(SIDE) || WIN % 2 != 0) begin : gParamCheck
        $error("frame side must be a power of two and window side even");
    end

    logic [PIX_W-1:0] bank0 [SIDE*SIDE];
    logic [PIX_W-1:0] bank1 [SIDE*SIDE];

    logic decWe0, decWe1;

    // load port wins, decimation write is dropped on a clash
    assign decWe0 = decWe & ~decBank & ~loadWe;
    assign decWe1 = decWe & decBank;

    always_ff @(posedge clk) begin
        if (loadWe) begin
            bank0[loadAddr] <= loadData;
        end else if (decWe0) begin
            bank0[decAddr] <= rdData;
        end
        if (decWe1) begin
            bank1[decAddr] <= rdData;   // same-cycle read data is the pixel to keep
        end
        if (rdEn) begin
            rdData <= rdBank ? bank1[rdAddr] : bank0[rdAddr];
        end
    end

endmodule

/* logic/pyramidSequencer.sv */
`timescale 1ns/1ps

module pyramidSequencer import pyramidPkg::*; #(
    parameter  int SIDE = 32,
    parameter  int WIN  = 8,
    localparam int CW   = $clog2(SIDE),
    localparam int AW   = 2 * CW,
    localparam int OW   = $clog2(WIN)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic             winValid,
    input  logic             winReady,
    output logic             busy,
    output logic             done,
    output logic             rdEn,
    output logic             rdBank,
    output logic [AW-1:0]    rdAddr,
    output logic             decWe,
    output logic             decBank,
    output logic [AW-1:0]    decAddr,
    output logic             pixVld,
    output logic             winStart,
    output logic [CW-1:0]    originX,
    output logic [CW-1:0]    originY,
    output logic [LVL_W-1:0] level
);

    localparam logic [CW-1:0] STEP = CW'(WIN / 2);     // half-window stride

    seqState_t state;

    logic [OW-1:0] offX, offY;      // position inside the window
    logic [CW-1:0] pixX, pixY;      // position inside the level
    logic [CW-1:0] lastOrigin;
    logic [CW-1:0] rdBase, decBase;
    int            curSide;

    //////////////////////////////////////////////////
    // level geometry
    //////////////////////////////////////////////////
    // level 0 stays whole in bank 0 so a restart can rerun the frame.
    // decimated levels are tiled along the columns of bank 1,
    // level L starting at column SIDE - 2*side(L)
    always_comb begin
        curSide    = levelSide(SIDE, int'(level));
        lastOrigin = CW'(curSide - WIN);
        rdBase     = CW'(SIDE - 2 * curSide);  // wraps to 0 for level 0
        decBase    = CW'(SIDE - curSide);      // base of the next level
    end

    assign pixX     = originX + CW'(offX);
    assign pixY     = originY + CW'(offY);
    assign rdEn     = (state == SCAN);
    assign rdAddr   = {pixY, rdBase + pixX};
    assign winStart = rdEn && (offX == '0) && (offY == '0);
    assign busy     = (state != IDLE);

    //////////////////////////////////////////////////
    // window and level walker
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            done    <= 1'b0;
            level   <= '0;
            rdBank  <= 1'b0;
            originX <= '0;
            originY <= '0;
            offX    <= '0;
            offY    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        done    <= 1'b0;
                        level   <= '0;
                        rdBank  <= 1'b0;
                        originX <= '0;
                        originY <= '0;
                        offX    <= '0;
                        offY    <= '0;
                        state   <= SCAN;
                    end
                end
                SCAN: begin
                    offX <= offX + 1'b1;            // wraps, WIN is a power of two
                    if (offX == OW'(WIN - 1)) begin
                        offY <= offY + 1'b1;
                        if (offY == OW'(WIN - 1)) state <= DRAIN;
                    end
                end
                DRAIN: state <= HANDOFF;
                HANDOFF: begin
                    if (winValid && winReady) begin
                        state <= SCAN;
                        if (originX == lastOrigin) begin
                            originX <= '0;
                            if (originY == lastOrigin) begin
                                originY <= '0;
                                state   <= NEXT_LEVEL;
                            end else begin
                                originY <= originY + STEP;
                            end
                        end else begin
                            originX <= originX + STEP;
                        end
                    end
                end
                NEXT_LEVEL: begin
                    if (levelSide(SIDE, int'(level) + 1) < WIN) begin
                        done  <= 1'b1;      // next level too small for a window
                        state <= IDLE;
                    end else begin
                        level  <= level + 1'b1;
                        rdBank <= 1'b1;
                        state  <= SCAN;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // decimation, one stage behind the read
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decWe  <= 1'b0;
            pixVld <= 1'b0;
        end else begin
            decWe  <= rdEn & ~pixX[0] & ~pixY[0];   // even pixels only
            pixVld <= rdEn;
        end
    end

    always_ff @(posedge clk) begin
        decBank <= 1'b1;    // every decimated level lands in bank 1
        decAddr <= {pixY >> 1, decBase + (pixX >> 1)};
    end

    // the window buffer is never overwritten while it waits
    assert property (@(posedge clk) disable iff (!rst_n) winValid |-> !rdEn)
        else $error("read issued while a window waits for hand-off");

endmodule

/* logic/windowAssembler.sv */
`timescale 1ns/1ps

module windowAssembler import pyramidPkg::*; #(
    parameter  int SIDE = 32,
    parameter  int WIN  = 8,
    localparam int CW   = $clog2(SIDE),
    localparam int NPIX = WIN * WIN,
    localparam int NW   = $clog2(NPIX)
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pixVld,
    input  logic [PIX_W-1:0]      rdData,
    input  logic                  winStart,
    input  logic [CW-1:0]         originX,
    input  logic [CW-1:0]         originY,
    input  logic [LVL_W-1:0]      level,
    input  logic                  winReady,
    output logic                  winValid,
    output logic [NPIX*PIX_W-1:0] winData,
    output logic [CW-1:0]         winX,
    output logic [CW-1:0]         winY,
    output logic [LVL_W-1:0]      winLevel
);

    logic [NW-1:0] pixCnt;
    logic          lastPix;

    assign lastPix = pixVld && (pixCnt == NW'(NPIX - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixCnt   <= '0;
            winValid <= 1'b0;
        end else begin
            if (winStart) begin
                pixCnt <= '0;
            end else if (pixVld) begin
                pixCnt <= pixCnt + 1'b1;    // wraps back to 0 on the last pixel
            end
            if (lastPix) begin
                winValid <= 1'b1;
            end else if (winValid && winReady) begin
                winValid <= 1'b0;
            end
        end
    end

    // raster order in, first pixel ends up in the low byte
    always_ff @(posedge clk) begin
        if (pixVld) winData <= {rdData, winData[NPIX*PIX_W-1:PIX_W]};
        if (winStart) begin
            winX     <= originX;
            winY     <= originY;
            winLevel <= level;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        winValid && !winReady |=> winValid && $stable(winData) && $stable(winX)
                                  && $stable(winY))
        else $error("window changed before it was accepted");

endmodule

/* logic/imagePyramid.sv */
`timescale 1ns/1ps

module imagePyramid import pyramidPkg::*; #(
    parameter  int SIDE = 32,
    parameter  int WIN  = 8,
    localparam int CW   = $clog2(SIDE),
    localparam int AW   = 2 * CW
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wbCyc,
    input  logic                     wbStb,
    input  logic                     wbWe,
    input  logic [15:0]              wbAdr,
    input  logic [PIX_W-1:0]         wbDatW,
    output logic [PIX_W-1:0]         wbDatR,
    output logic                     wbAck,
    output logic                     winValid,
    input  logic                     winReady,
    output logic [WIN*WIN*PIX_W-1:0] winData,
    output logic [CW-1:0]            winX,
    output logic [CW-1:0]            winY,
    output logic [LVL_W-1:0]         winLevel
);

    // loader side
    logic             loadWe;
    logic [AW-1:0]    loadAddr;
    logic [PIX_W-1:0] loadData;
    logic             start, busy, done;

    // read and decimation path
    logic             rdEn, rdBank, decWe, decBank;
    logic [AW-1:0]    rdAddr, decAddr;
    logic [PIX_W-1:0] rdData;

    // window hand-over
    logic             pixVld, winStart;
    logic [CW-1:0]    originX, originY;
    logic [LVL_W-1:0] level;

    wbFrameLoader #(.SIDE(SIDE), .WIN(WIN)) uLoader (
        .clk, .rst_n, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .busy, .done,
        .wbDatR, .wbAck, .loadWe, .loadAddr, .loadData, .start
    );

    frameRam #(.SIDE(SIDE), .WIN(WIN)) uRam (
        .clk, .loadWe, .loadAddr, .loadData, .decWe, .decBank, .decAddr,
        .rdEn, .rdBank, .rdAddr, .rdData
    );

    pyramidSequencer #(.SIDE(SIDE), .WIN(WIN)) uSeq (
        .clk, .rst_n, .start, .winValid, .winReady, .busy, .done,
        .rdEn, .rdBank, .rdAddr, .decWe, .decBank, .decAddr,
        .pixVld, .winStart, .originX, .originY, .level
    );

    windowAssembler #(.SIDE(SIDE), .WIN(WIN)) uAsm (
        .clk, .rst_n, .pixVld, .rdData, .winStart, .originX, .originY, .level,
        .winReady, .winValid, .winData, .winX, .winY, .winLevel
    );

endmodule

/* bench/pyramidTbUtil.svh */
`ifndef PYRAMID_TB_UTIL_SVH
`define PYRAMID_TB_UTIL_SVH

localparam logic [31:0] SEED = 32'h08a1f4e7;
localparam int MAX_DELAY = 7;      // ready held low for 0..7 cycles

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
endfunction

// levels whose side still holds one window
function automatic int countLevels(input int side, input int win);
    int n;
    n = 0;
    while ((side >> n) >= win) n++;
    return n;
endfunction

function automatic int windowCount(input int side, input int win);
    int n, l, per;
    n = 0;
    for (l = 0; (side >> l) >= win; l++) begin
        per = ((side >> l) - win) / (win / 2) + 1;    // origins per row
        n += per * per;
    end
    return n;
endfunction

localparam int NLVL = countLevels(SIDE, WIN);
localparam int NWIN = windowCount(SIDE, WIN);

// two cycles per load write, then two runs at the longest ready delay
localparam int TIMEOUT_CYCLES =
    2 * (2 * SIDE * SIDE + 2 * NWIN * (NPIX + 2 + MAX_DELAY));

logic [7:0] pyr [NLVL][SIDE][SIDE];    // golden pyramid, level 0 is the frame
int expX[$];
int expY[$];
int expL[$];

//////////////////////////////////////////////////
// golden model
//////////////////////////////////////////////////
// each level keeps the even rows and columns of the one above
task automatic buildPyramid();
    int l, y, x, s;
    for (l = 1; l < NLVL; l++) begin
        s = levelSide(SIDE, l);
        for (y = 0; y < s; y++) begin
            for (x = 0; x < s; x++) begin
                pyr[l][y][x] = pyr[l-1][2*y][2*x];
            end
        end
    end
endtask

// level, then origin row, then origin column
task automatic listWindows();
    int l, ox, oy;
    for (l = 0; l < NLVL; l++) begin
        for (oy = 0; oy <= levelSide(SIDE, l) - WIN; oy += WIN / 2) begin
            for (ox = 0; ox <= levelSide(SIDE, l) - WIN; ox += WIN / 2) begin
                expL.push_back(l);
                expY.push_back(oy);
                expX.push_back(ox);
            end
        end
    end
endtask

function automatic logic [NPIX*8-1:0] expectedWindow(input int l, input int ox, input int oy);
    logic [NPIX*8-1:0] w;
    int r, c;
    for (r = 0; r < WIN; r++) begin
        for (c = 0; c < WIN; c++) begin
            w[(r*WIN+c)*8 +: 8] = pyr[l][oy+r][ox+c];    // row 0 col 0 lowest
        end
    end
    return w;
endfunction

//////////////////////////////////////////////////
// wishbone master
//////////////////////////////////////////////////
task automatic wbCycle(input logic we, input logic [15:0] adr, input logic [7:0] wdat,
                       output logic [7:0] rdat);
    @(negedge clk);
    if (wbAck !== 1'b0) begin
        reportFail(curTest, "wbAck still high from the previous cycle");
    end
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = we;
    wbAdr  = adr;
    wbDatW = wdat;
    @(negedge clk);
    if (wbAck !== 1'b1) begin
        reportFail(curTest, $sformatf("no ack one cycle after strobe, adr %h", adr));
    end
    rdat  = wbDatR;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
endtask

task automatic wbWrite(input logic [15:0] adr, input logic [7:0] dat);
    logic [7:0] unused;
    wbCycle(1'b1, adr, dat, unused);
endtask

task automatic wbRead(input logic [15:0] adr, output logic [7:0] dat);
    wbCycle(1'b0, adr, 8'h00, dat);
endtask

`endif

/* bench/imagePyramidTb.sv */
`timescale 1ns/1ps

module imagePyramidTb import pyramidPkg::*; ();

    localparam int SIDE        = 32;
    localparam int WIN         = 8;
    localparam int CW          = $clog2(SIDE);
    localparam int NPIX        = WIN * WIN;
    localparam int BUSY_WRITES = 16;

    logic                  clk;
    logic                  rst_n;
    logic                  wbCyc, wbStb, wbWe, wbAck;
    logic [15:0]           wbAdr;
    logic [PIX_W-1:0]      wbDatW, wbDatR;
    logic                  winValid, winReady;
    logic [NPIX*PIX_W-1:0] winData;
    logic [CW-1:0]         winX, winY;
    logic [LVL_W-1:0]      winLevel;

    int          errs [1:6];    // per test
    int          curTest, accepted, failedTests, cycles;
    logic [31:0] rng, winRng, busRng;
    logic        runOver;       // status poll has seen done

    task automatic reportFail(input int t, input string msg);
        errs[t]++;
        $display("FAIL %0t: test %0d, %s", $time, t, msg);
    endtask

    `include "pyramidTbUtil.svh"

    imagePyramid #(.SIDE(SIDE), .WIN(WIN)) DUT (
        .clk, .rst_n, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck,
        .winValid, .winReady, .winData, .winX, .winY, .winLevel
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: the run hung, no finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // window sink with random back-pressure
    //////////////////////////////////////////////////
    task automatic collectWindows(input int dataTest, input int deepTest, input int holdTest);
        logic [NPIX*PIX_W-1:0] data;
        int x, y, l, delay, tst, i, prevX, prevY, prevL;
        prevX = -1;
        prevY = -1;
        prevL = -1;
        i = 0;
        // keeps taking windows until done is seen and nothing is left
        while (winValid === 1'b1 || !runOver) begin
            if (winValid !== 1'b1) begin
                @(negedge clk);
            end else begin
                data = winData;
                x = winX;
                y = winY;
                l = winLevel;
                winRng = xorshift32(winRng);
                delay = winRng % (MAX_DELAY + 1);
                repeat (delay) begin
                    @(negedge clk);
                    if (winValid !== 1'b1 || winData !== data || winX != x || winY != y
                            || winLevel != l) begin
                        reportFail(holdTest, $sformatf("window %0d changed before accept", i));
                    end
                end
                winReady = 1'b1;
                @(negedge clk);
                winReady = 1'b0;
                accepted++;
                if (x == prevX && y == prevY && l == prevL) begin
                    reportFail(holdTest, $sformatf("window %0d repeats the one before", i));
                end
                prevX = x;
                prevY = y;
                prevL = l;
                if (i >= expL.size()) begin
                    reportFail(deepTest, $sformatf("window %0d is beyond the model's list", i));
                end else begin
                    tst = (expL[i] == 0) ? dataTest : deepTest;
                    if (l != expL[i] || y != expY[i] || x != expX[i]) begin
                        reportFail(tst, $sformatf(
                                   "window %0d is L%0d (%0d,%0d), expected L%0d (%0d,%0d)",
                                   i, l, x, y, expL[i], expX[i], expY[i]));
                    end else if (data !== expectedWindow(l, x, y)) begin
                        reportFail(tst, $sformatf(
                                   "window %0d L%0d (%0d,%0d) pixels differ from model",
                                   i, l, x, y));
                    end
                end
                i++;
            end
        end
    endtask

    task automatic busyWrites();
        logic [7:0] s;
        int n;
        wbRead(CTRL_ADDR, s);
        if (s[STAT_BUSY] !== 1'b1) begin
            reportFail(6, "unit not busy when the busy-time writes began");
        end
        for (n = 0; n < BUSY_WRITES; n++) begin
            busRng = xorshift32(busRng);
            wbWrite(16'(busRng % (SIDE * SIDE)), busRng[31:24]);
        end
    endtask

    task automatic waitDone(input int t);
        logic [7:0] s;
        s = '0;
        while (s[STAT_DONE] !== 1'b1) wbRead(CTRL_ADDR, s);
        if (s[STAT_BUSY] !== 1'b0) begin
            reportFail(t, "busy still set together with done");
        end
        runOver = 1'b1;
    endtask

    task automatic startRun();
        wbWrite(CTRL_ADDR, 8'h01);
        @(negedge clk);     // status register lags busy by a cycle
        accepted = 0;
        runOver  = 1'b0;
    endtask

    task automatic checkCount(input int t);
        repeat (4) @(negedge clk);
        if (accepted != expL.size() || winValid !== 1'b0) begin
            reportFail(t, $sformatf("%0d windows accepted, valid %b, model has %0d",
                       accepted, winValid, expL.size()));
        end
    endtask

    task automatic endTest(input int t, input string name);
        if (errs[t] == 0) begin
            $display("test %0d %s: ok", t, name);
        end else begin
            $display("test %0d %s: %0d error(s)", t, name, errs[t]);
            failedTests++;
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin
        int a;
        logic [7:0] pix;
        logic [7:0] st;
        clk      = 1'b0;
        rst_n    = 1'b0;
        wbCyc    = 1'b0;
        wbStb    = 1'b0;
        wbWe     = 1'b0;
        wbAdr    = '0;
        wbDatW   = '0;
        winReady = 1'b0;
        runOver  = 1'b0;
        rng      = SEED;
        foreach (errs[i]) errs[i] = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        curTest = 1;
        if (winValid !== 1'b0 || wbAck !== 1'b0) begin
            reportFail(1, "winValid or wbAck high after reset");
        end
        wbRead(CTRL_ADDR, st);
        if (st[1:0] !== 2'b00) begin
            reportFail(1, $sformatf("status %b after reset, expected 00", st[1:0]));
        end
        endTest(1, "reset state");

        curTest = 2;
        for (a = 0; a < SIDE * SIDE; a++) begin
            rng = xorshift32(rng);
            pix = rng[7:0];
            pyr[0][a / SIDE][a % SIDE] = pix;
            wbWrite(16'(a), pix);
        end
        wbRead(CTRL_ADDR, st);
        if (st[1:0] !== 2'b00) begin
            reportFail(2, $sformatf("status %b after load, expected 00", st[1:0]));
        end
        buildPyramid();
        listWindows();
        endTest(2, "frame load");

        // first run, busy-time writes go out alongside
        curTest = 6;
        winRng = xorshift32(rng);
        busRng = xorshift32(rng ^ 32'h5a5a_5a5a);
        startRun();
        fork
            collectWindows(3, 4, 5);
            begin
                busyWrites();
                waitDone(4);
            end
        join
        checkCount(4);
        endTest(3, "level 0 windows");
        endTest(4, "decimated levels");
        endTest(5, "back-pressure");

        // rerun on the same frame, nothing reloaded
        startRun();
        fork
            collectWindows(6, 6, 6);
            waitDone(6);
        join
        checkCount(6);
        endTest(6, "busy-time writes and restart");

        $display("6 tests run, %0d passed, %0d failed", 6 - failedTests, failedTests);
        if (failedTests == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+bench
logic/pyramidPkg.sv
logic/wbFrameLoader.sv
logic/frameRam.sv
logic/pyramidSequencer.sv
logic/windowAssembler.sv
logic/imagePyramid.sv
bench/imagePyramidTb.sv

/* Bender.yml */
package:
  name: image_pyramid

sources:
  - logic/pyramidPkg.sv
  - logic/wbFrameLoader.sv
  - logic/frameRam.sv
  - logic/pyramidSequencer.sv
  - logic/windowAssembler.sv
  - logic/imagePyramid.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/imagePyramidTb.sv
